// File: hdl/spm_map_pkg.sv
// SPM address map package
// Widths, port counts, configuration register indices, reset values
// and the request target encoding shared by the subsystem

package spm_map_pkg;

  // ----------------------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------------------
  localparam int unsigned NUM_CORES  = 2;
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned DATA_W     = 32;
  // Word index inside one SPM bank, 256 words
  localparam int unsigned SPM_ADDR_W = 8;
  // Byte offset bits below the word index
  localparam int unsigned BYTE_OFF_W = $clog2(DATA_W / 8);

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [DATA_W/8-1:0]   strb_t;
  typedef logic [0:0]            core_id_t;
  typedef logic [1:0]            cfg_addr_t;

  // ----------------------------------------------------------------------
  // Configuration registers
  // ----------------------------------------------------------------------
  localparam cfg_addr_t CFG_TCDM_START = 2'd0;
  localparam cfg_addr_t CFG_TCDM_END   = 2'd1;
  localparam cfg_addr_t CFG_SPM_SIZE   = 2'd2;
  localparam cfg_addr_t CFG_FLUSH      = 2'd3;

  // 2 KiB window, upper 1 KiB mapped to the SPM after reset
  localparam addr_t TCDM_START_RST = 32'h1000_0000;
  localparam addr_t TCDM_END_RST   = 32'h1000_0800;
  localparam addr_t SPM_SIZE_RST   = 32'h0000_0400;

  // Destination of a decoded request
  typedef enum logic [1:0] {
    TGT_SPM   = 2'd0,
    TGT_CACHE = 2'd1,
    TGT_ERR   = 2'd2
  } target_e;

endpackage

// File: hdl/mem_port_if.sv
// Memory port bundle
// Valid/ready request channel and a valid-only response channel

`timescale 1ns/1ps

interface mem_port_if import spm_map_pkg::*; ();

  // Request channel
  logic     q_valid;
  logic     q_ready;
  addr_t    addr;
  logic     write;
  data_t    wdata;
  strb_t    strb;
  core_id_t core_id;

  // Response channel, no back-pressure
  logic     p_valid;
  data_t    p_data;

  modport master (
    output q_valid, addr, write, wdata, strb, core_id,
    input  q_ready, p_valid, p_data
  );

  modport slave (
    input  q_valid, addr, write, wdata, strb, core_id,
    output q_ready, p_valid, p_data
  );

  modport monitor (
    input q_valid, q_ready, addr, write, wdata, strb, core_id, p_valid, p_data
  );

endinterface

// File: hdl/spm_cfg_regs.sv
// SPM configuration registers
// TCDM window, SPM size and flush bit, written by single-cycle strobes.
// Also keeps a registered copy of the SPM start address (end - size)

`timescale 1ns/1ps

module spm_cfg_regs import spm_map_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      cfg_we_i,
  input  cfg_addr_t cfg_addr_i,
  input  data_t     cfg_wdata_i,
  output addr_t     tcdm_start_o,
  output addr_t     tcdm_end_o,
  output addr_t     spm_start_o,
  output logic      flush_o
);

  addr_t tcdm_start_q;
  addr_t tcdm_end_q;
  addr_t spm_size_q;
  addr_t spm_start_q;
  logic  flush_q;

  // Next values of end and size, so the start tracks them without a lag
  addr_t tcdm_end_d;
  addr_t spm_size_d;

  assign tcdm_end_d = (cfg_we_i && cfg_addr_i == CFG_TCDM_END) ? cfg_wdata_i : tcdm_end_q;
  assign spm_size_d = (cfg_we_i && cfg_addr_i == CFG_SPM_SIZE) ? cfg_wdata_i : spm_size_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tcdm_start_q <= TCDM_START_RST;
      tcdm_end_q   <= TCDM_END_RST;
      spm_size_q   <= SPM_SIZE_RST;
      spm_start_q  <= TCDM_END_RST - SPM_SIZE_RST;
      flush_q      <= 1'b0;
    end else begin
      if (cfg_we_i && cfg_addr_i == CFG_TCDM_START) begin
        tcdm_start_q <= cfg_wdata_i;
      end
      if (cfg_we_i && cfg_addr_i == CFG_FLUSH) begin
        flush_q <= cfg_wdata_i[0];
      end
      tcdm_end_q  <= tcdm_end_d;
      spm_size_q  <= spm_size_d;
      spm_start_q <= tcdm_end_d - spm_size_d;
    end
  end

  assign tcdm_start_o = tcdm_start_q;
  assign tcdm_end_o   = tcdm_end_q;
  assign spm_start_o  = spm_start_q;
  assign flush_o      = flush_q;

  // SPM must fit below the window end, or the start address wraps
  a_size_fits: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (cfg_we_i && cfg_addr_i == CFG_SPM_SIZE) |-> (addr_t'(cfg_wdata_i) <= tcdm_end_q))
    else $error("SPM size larger than TCDM window end");

endmodule

// File: hdl/spm_addr_mapper.sv
// SPM address mapper
// Decodes each core request to the SPM, the cache or an error,
// gates requests while flushing and merges the two response streams
// with SPM priority

`timescale 1ns/1ps

module spm_addr_mapper import spm_map_pkg::*; (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  mem_port_if.slave            core_port  [NUM_CORES],
  mem_port_if.master           spm_port   [NUM_CORES],
  mem_port_if.master           cache_port [NUM_CORES],
  output logic [NUM_CORES-1:0] cache_p_ready_o,
  input  addr_t                tcdm_start_i,
  input  addr_t                tcdm_end_i,
  input  addr_t                spm_start_i,
  input  logic                 flush_i,
  output logic [NUM_CORES-1:0] error_o
);

  for (genvar i = 0; i < NUM_CORES; i++) begin : gen_port
    target_e tgt;
    logic    in_window;
    logic    err_q;

    // --------------------------------------------------------------------
    // Request side
    // --------------------------------------------------------------------
    assign in_window = (core_port[i].addr >= tcdm_start_i) &&
                       (core_port[i].addr <  tcdm_end_i);

    // SPM sits at the top of the window, the rest of the window is a hole
    always_comb begin
      if (!in_window) begin
        tgt = TGT_CACHE;
      end else if (core_port[i].addr >= spm_start_i) begin
        tgt = TGT_SPM;
      end else begin
        tgt = TGT_ERR;
      end
    end

    // Bank sees a word index only
    assign spm_port[i].addr    = addr_t'(core_port[i].addr[SPM_ADDR_W+BYTE_OFF_W-1:BYTE_OFF_W]);
    assign spm_port[i].write   = core_port[i].write;
    assign spm_port[i].wdata   = core_port[i].wdata;
    assign spm_port[i].strb    = core_port[i].strb;
    assign spm_port[i].core_id = core_port[i].core_id;
    assign spm_port[i].q_valid = core_port[i].q_valid && (tgt == TGT_SPM) && !flush_i;

    assign cache_port[i].addr    = core_port[i].addr;
    assign cache_port[i].write   = core_port[i].write;
    assign cache_port[i].wdata   = core_port[i].wdata;
    assign cache_port[i].strb    = core_port[i].strb;
    assign cache_port[i].core_id = core_port[i].core_id;
    assign cache_port[i].q_valid = core_port[i].q_valid && (tgt == TGT_CACHE) && !flush_i;

    // Error requests are swallowed right away
    always_comb begin
      case (tgt)
        TGT_SPM:   core_port[i].q_ready = spm_port[i].q_ready && !flush_i;
        TGT_CACHE: core_port[i].q_ready = cache_port[i].q_ready && !flush_i;
        default:   core_port[i].q_ready = !flush_i;
      endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        err_q <= 1'b0;
      end else begin
        err_q <= core_port[i].q_valid && core_port[i].q_ready && (tgt == TGT_ERR);
      end
    end

    assign error_o[i] = err_q;

    // --------------------------------------------------------------------
    // Response side
    // --------------------------------------------------------------------
    // SPM wins, the cache holds its response until the slot is free
    assign cache_p_ready_o[i]  = !spm_port[i].p_valid;
    assign core_port[i].p_valid = spm_port[i].p_valid || cache_port[i].p_valid;
    assign core_port[i].p_data  = spm_port[i].p_valid ? spm_port[i].p_data
                                                      : cache_port[i].p_data;

    // A held-off cache response must still be there in the next cycle
    a_cache_rsp_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (cache_port[i].p_valid && !cache_p_ready_o[i]) |=>
        (cache_port[i].p_valid && $stable(cache_port[i].p_data)))
      else $error("Cache response on port %0d dropped while held off", i);
  end

endmodule

// File: hdl/cache_port_arb.sv
// Cache port arbiter
// Locking round-robin of the core requests onto one cache port.
// Responses are steered back by their core_id tag

`timescale 1ns/1ps

module cache_port_arb import spm_map_pkg::*; (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  mem_port_if.slave            req_port [NUM_CORES],
  mem_port_if.master           cache_port,
  input  core_id_t             cache_p_core_id_i,
  input  logic [NUM_CORES-1:0] cache_p_ready_i,
  output logic                 p_ready_o
);

  logic [NUM_CORES-1:0] req_valid;
  logic [NUM_CORES-1:0] gnt;
  addr_t                req_addr  [NUM_CORES];
  logic                 req_write [NUM_CORES];
  data_t                req_wdata [NUM_CORES];
  strb_t                req_strb  [NUM_CORES];

  core_id_t gnt_idx;
  logic     gnt_valid;
  logic     locked_q;
  core_id_t lock_idx_q;
  core_id_t prio_q;

  for (genvar i = 0; i < NUM_CORES; i++) begin : gen_req
    assign req_valid[i] = req_port[i].q_valid;
    assign req_addr[i]  = req_port[i].addr;
    assign req_write[i] = req_port[i].write;
    assign req_wdata[i] = req_port[i].wdata;
    assign req_strb[i]  = req_port[i].strb;

    assign gnt[i]              = gnt_valid && (gnt_idx == core_id_t'(i));
    assign req_port[i].q_ready = gnt[i] && cache_port.q_ready;

    // Response goes only to the tagged core
    assign req_port[i].p_valid = cache_port.p_valid && (cache_p_core_id_i == core_id_t'(i));
    assign req_port[i].p_data  = cache_port.p_data;
  end

  // Held grant first, then the core with priority, then the other one
  always_comb begin
    if (locked_q) begin
      gnt_idx = lock_idx_q;
    end else if (req_valid[prio_q]) begin
      gnt_idx = prio_q;
    end else begin
      gnt_idx = ~prio_q;
    end
  end

  assign gnt_valid = req_valid[gnt_idx];

  assign cache_port.q_valid = gnt_valid;
  assign cache_port.addr    = req_addr[gnt_idx];
  assign cache_port.write   = req_write[gnt_idx];
  assign cache_port.wdata   = req_wdata[gnt_idx];
  assign cache_port.strb    = req_strb[gnt_idx];
  assign cache_port.core_id = gnt_idx;

  assign p_ready_o = cache_p_ready_i[cache_p_core_id_i];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      locked_q   <= 1'b0;
      lock_idx_q <= '0;
      prio_q     <= '0;
    end else begin
      locked_q   <= gnt_valid && !cache_port.q_ready;
      lock_idx_q <= gnt_idx;
      // Loser of this transfer goes first next time
      if (gnt_valid && cache_port.q_ready) begin
        prio_q <= ~gnt_idx;
      end
    end
  end

  // A stalled request stays in place until the cache takes it
  a_gnt_locked: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (cache_port.q_valid && !cache_port.q_ready) |=>
      (cache_port.q_valid && $stable(cache_port.core_id) && $stable(cache_port.addr)))
    else $error("Cache request changed before it was accepted");

endmodule

// File: hdl/spm_bank.sv
// Scratchpad bank
// Single-port word RAM with byte strobes. Always ready, the response
// comes one cycle after the request, with the old word on a write

`timescale 1ns/1ps

module spm_bank import spm_map_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  mem_port_if.slave port
);

  localparam int unsigned NUM_WORDS = 2 ** SPM_ADDR_W;

  data_t                 mem [NUM_WORDS];
  data_t                 p_data_q;
  logic                  p_valid_q;
  logic [SPM_ADDR_W-1:0] word_idx;

  assign word_idx     = port.addr[SPM_ADDR_W-1:0];
  assign port.q_ready = 1'b1;

  // ----------------------------------------------------------------------
  // Storage and read data
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (port.q_valid) begin
      p_data_q <= mem[word_idx];
      if (port.write) begin
        for (int b = 0; b < DATA_W / 8; b++) begin
          if (port.strb[b]) begin
            mem[word_idx][b*8 +: 8] <= port.wdata[b*8 +: 8];
          end
        end
      end
    end
  end

  // Response strobe
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      p_valid_q <= 1'b0;
    end else begin
      p_valid_q <= port.q_valid;
    end
  end

  assign port.p_valid = p_valid_q;
  assign port.p_data  = p_data_q;

endmodule

// File: hdl/spm_subsys_top.sv
// SPM subsystem top level
// Two cores, one SPM bank each and a shared cache port, with the
// configuration registers beside the address mapper

`timescale 1ns/1ps

module spm_subsys_top import spm_map_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Configuration
  input  logic                  cfg_we_i,
  input  cfg_addr_t             cfg_addr_i,
  input  data_t                 cfg_wdata_i,
  // Core ports
  input  logic  [NUM_CORES-1:0] core_q_valid_i,
  output logic  [NUM_CORES-1:0] core_q_ready_o,
  input  addr_t [NUM_CORES-1:0] core_addr_i,
  input  logic  [NUM_CORES-1:0] core_write_i,
  input  data_t [NUM_CORES-1:0] core_wdata_i,
  input  strb_t [NUM_CORES-1:0] core_strb_i,
  output logic  [NUM_CORES-1:0] core_p_valid_o,
  output data_t [NUM_CORES-1:0] core_p_data_o,
  output logic  [NUM_CORES-1:0] core_error_o,
  // Cache port
  output logic                  cache_q_valid_o,
  input  logic                  cache_q_ready_i,
  output addr_t                 cache_addr_o,
  output logic                  cache_write_o,
  output data_t                 cache_wdata_o,
  output strb_t                 cache_strb_o,
  output core_id_t              cache_core_id_o,
  input  logic                  cache_p_valid_i,
  input  data_t                 cache_p_data_i,
  input  core_id_t              cache_p_core_id_i,
  output logic                  cache_p_ready_o
);

  addr_t                tcdm_start;
  addr_t                tcdm_end;
  addr_t                spm_start;
  logic                 flush;
  logic [NUM_CORES-1:0] cache_p_ready;

  mem_port_if core_if  [NUM_CORES] ();
  mem_port_if spm_if   [NUM_CORES] ();
  mem_port_if cache_if [NUM_CORES] ();
  mem_port_if cache_ext_if ();

  for (genvar i = 0; i < NUM_CORES; i++) begin : gen_core
    assign core_if[i].q_valid = core_q_valid_i[i];
    assign core_if[i].addr    = core_addr_i[i];
    assign core_if[i].write   = core_write_i[i];
    assign core_if[i].wdata   = core_wdata_i[i];
    assign core_if[i].strb    = core_strb_i[i];
    assign core_if[i].core_id = core_id_t'(i);
    assign core_q_ready_o[i]  = core_if[i].q_ready;
    assign core_p_valid_o[i]  = core_if[i].p_valid;
    assign core_p_data_o[i]   = core_if[i].p_data;

    spm_bank u_spm_bank (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .port     (spm_if[i])
    );
  end

  // ----------------------------------------------------------------------
  // External cache port
  // ----------------------------------------------------------------------
  assign cache_q_valid_o        = cache_ext_if.q_valid;
  assign cache_addr_o           = cache_ext_if.addr;
  assign cache_write_o          = cache_ext_if.write;
  assign cache_wdata_o          = cache_ext_if.wdata;
  assign cache_strb_o           = cache_ext_if.strb;
  assign cache_core_id_o        = cache_ext_if.core_id;
  assign cache_ext_if.q_ready   = cache_q_ready_i;
  assign cache_ext_if.p_valid   = cache_p_valid_i;
  assign cache_ext_if.p_data    = cache_p_data_i;

  spm_cfg_regs u_cfg_regs (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .cfg_we_i     (cfg_we_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .tcdm_start_o (tcdm_start),
    .tcdm_end_o   (tcdm_end),
    .spm_start_o  (spm_start),
    .flush_o      (flush)
  );

  spm_addr_mapper u_addr_mapper (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .core_port       (core_if),
    .spm_port        (spm_if),
    .cache_port      (cache_if),
    .cache_p_ready_o (cache_p_ready),
    .tcdm_start_i    (tcdm_start),
    .tcdm_end_i      (tcdm_end),
    .spm_start_i     (spm_start),
    .flush_i         (flush),
    .error_o         (core_error_o)
  );

  cache_port_arb u_cache_arb (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .req_port          (cache_if),
    .cache_port        (cache_ext_if),
    .cache_p_core_id_i (cache_p_core_id_i),
    .cache_p_ready_i   (cache_p_ready),
    .p_ready_o         (cache_p_ready_o)
  );

endmodule

// File: sim/spm_subsys_checker.sv
// SPM subsystem checker
// Follows the configuration, decodes each accepted request on its own
// and compares responses, error pulses and cache requests

`timescale 1ns/1ps

module spm_subsys_checker import spm_map_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  cfg_we_i,
  input  cfg_addr_t             cfg_addr_i,
  input  data_t                 cfg_wdata_i,
  input  logic  [NUM_CORES-1:0] core_q_valid_i,
  input  logic  [NUM_CORES-1:0] core_q_ready_i,
  input  addr_t [NUM_CORES-1:0] core_addr_i,
  input  logic  [NUM_CORES-1:0] core_write_i,
  input  data_t [NUM_CORES-1:0] core_wdata_i,
  input  strb_t [NUM_CORES-1:0] core_strb_i,
  input  logic  [NUM_CORES-1:0] core_p_valid_i,
  input  data_t [NUM_CORES-1:0] core_p_data_i,
  input  logic  [NUM_CORES-1:0] core_error_i,
  input  logic                  cache_q_valid_i,
  input  logic                  cache_q_ready_i,
  input  addr_t                 cache_addr_i,
  input  logic                  cache_write_i,
  input  data_t                 cache_wdata_i,
  input  strb_t                 cache_strb_i,
  input  core_id_t              cache_core_id_i,
  input  logic                  cache_p_valid_i,
  input  data_t                 cache_p_data_i,
  input  core_id_t              cache_p_core_id_i,
  input  logic                  cache_p_ready_i,
  output int                    pending_o,
  output int                    checks_o,
  output int                    errors_o
);

  localparam data_t FILL = 32'h5a5a_a5a5;

  typedef struct {
    int    core;
    int    kind;
    logic  chk;
    data_t exp;
    addr_t addr;
    logic  write;
    data_t wdata;
    strb_t strb;
  } exp_t;

  exp_t  issued[$];
  exp_t  cache_req[$];
  exp_t  cache_rsp[$];
  data_t spm_ref [NUM_CORES][256];
  data_t cache_ref [addr_t];
  data_t spm_exp [NUM_CORES];
  logic  [NUM_CORES-1:0] spm_due;
  logic  [NUM_CORES-1:0] err_due;
  addr_t win_start;
  addr_t win_end;
  addr_t spm_size;
  logic  flush_ref;
  int    pending = 0;
  int    checks = 0;
  int    errors = 0;

  assign pending_o = pending;
  assign checks_o  = checks;
  assign errors_o  = errors;

  task automatic add_expect(input int c, input int kind, input logic chk, input data_t exp);
    exp_t e;
    e.core = c;
    e.kind = kind;
    e.chk  = chk;
    e.exp  = exp;
    issued.push_back(e);
    pending++;
  endtask

  task automatic check_val(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic fail(input string what);
    errors++;
    $display("t=%0t %s", $time, what);
  endtask

  function automatic int first_of(input exp_t q[$], input int c);
    foreach (q[k]) begin
      if (q[k].core == c) return k;
    end
    return -1;
  endfunction

  // 0 SPM, 1 cache, 2 hole in the window
  function automatic int decode(input addr_t a);
    if (a < win_start || a >= win_end) return 1;
    if (a >= win_end - spm_size) return 0;
    return 2;
  endfunction

  always @(negedge clk_i or negedge arst_n_i) begin
    int    idx;
    int    tgt;
    exp_t  e;
    data_t old;
    if (!arst_n_i) begin
      spm_due   = '0;
      err_due   = '0;
      flush_ref = 1'b0;
      win_start = TCDM_START_RST;
      win_end   = TCDM_END_RST;
      spm_size  = SPM_SIZE_RST;
    end else begin
      for (int c = 0; c < NUM_CORES; c++) begin
        // ----------------------------------------------------------------
        // Responses of this cycle
        // ----------------------------------------------------------------
        if (spm_due[c]) begin
          check_val($sformatf("core_p_valid_o[%0d]", c), core_p_valid_i[c], 1);
          check_val($sformatf("core_p_data_o[%0d]", c), core_p_data_i[c], spm_exp[c]);
          pending--;
          if (cache_p_valid_i && cache_p_core_id_i == c && cache_p_ready_i)
            fail("cache response accepted while an SPM response is present");
        end else if (cache_p_valid_i && cache_p_core_id_i == c) begin
          idx = first_of(cache_rsp, c);
          if (idx < 0) begin
            fail($sformatf("cache response for core %0d with nothing outstanding", c));
          end else begin
            check_val("cache_p_ready_o", cache_p_ready_i, 1);
            check_val($sformatf("core_p_valid_o[%0d]", c), core_p_valid_i[c], 1);
            check_val($sformatf("core_p_data_o[%0d]", c), core_p_data_i[c],
                      cache_rsp[idx].exp);
            cache_rsp.delete(idx);
            pending--;
          end
        end else if (core_p_valid_i[c]) begin
          fail($sformatf("unexpected response on core %0d", c));
        end
        check_val($sformatf("core_error_o[%0d]", c), core_error_i[c], err_due[c]);
        if (err_due[c]) pending--;
        spm_due[c] = 1'b0;
        err_due[c] = 1'b0;
        if (flush_ref && core_q_ready_i[c])
          fail($sformatf("core %0d accepts a request during flush", c));

        // Accepted request, decoded against the current window
        if (core_q_valid_i[c] && core_q_ready_i[c]) begin
          idx = first_of(issued, c);
          if (idx < 0) begin
            fail($sformatf("core %0d request accepted that was never issued", c));
          end else begin
            e = issued[idx];
            issued.delete(idx);
            tgt = decode(core_addr_i[c]);
            check_val($sformatf("target of core %0d", c), tgt, e.kind);
            e.addr  = core_addr_i[c];
            e.write = core_write_i[c];
            e.wdata = core_wdata_i[c];
            e.strb  = core_strb_i[c];
            if (tgt == 0) begin
              idx = e.addr[9:2];
              spm_exp[c] = e.chk ? e.exp : spm_ref[c][idx];
              if (e.write) spm_ref[c][idx] = e.wdata;
              spm_due[c] = 1'b1;
            end else if (tgt == 1) begin
              cache_req.push_back(e);
            end else begin
              err_due[c] = 1'b1;
            end
          end
        end
      end

      if (flush_ref && cache_q_valid_i) fail("cache request issued during flush");

      // --------------------------------------------------------------------
      // Cache side
      // --------------------------------------------------------------------
      if (cache_q_valid_i && cache_q_ready_i) begin
        idx = first_of(cache_req, cache_core_id_i);
        if (idx < 0) begin
          fail("cache request with no pending core request");
        end else begin
          e = cache_req[idx];
          cache_req.delete(idx);
          check_val("cache_addr_o", cache_addr_i, e.addr);
          check_val("cache_write_o", cache_write_i, e.write);
          check_val("cache_strb_o", cache_strb_i, e.strb);
          old = cache_ref.exists(e.addr) ? cache_ref[e.addr] : (e.addr ^ FILL);
          if (e.write) begin
            check_val("cache_wdata_o", cache_wdata_i, e.wdata);
            cache_ref[e.addr] = e.wdata;
          end
          if (!e.chk) e.exp = old;
          cache_rsp.push_back(e);
        end
      end

      // Configuration takes effect at the next edge
      if (cfg_we_i) begin
        case (cfg_addr_i)
          CFG_TCDM_START: win_start = cfg_wdata_i;
          CFG_TCDM_END:   win_end   = cfg_wdata_i;
          CFG_SPM_SIZE:   spm_size  = cfg_wdata_i;
          default:        flush_ref = cfg_wdata_i[0];
        endcase
      end
    end
  end

endmodule

// File: sim/spm_subsys_tb.sv
// SPM subsystem testbench
// Runs the operations from the stimulus file in batches, with a
// cache memory model of random latency on the shared cache port

`timescale 1ns/1ps

module spm_subsys_tb import spm_map_pkg::*; ();

  localparam data_t FILL = 32'h5a5a_a5a5;

  typedef struct {
    int    op;
    int    core;
    int    kind;
    addr_t addr;
    data_t data;
    data_t exp;
  } line_t;

  logic                  clk;
  logic                  arst_n;
  logic                  cfg_we;
  cfg_addr_t             cfg_addr;
  data_t                 cfg_wdata;
  logic  [NUM_CORES-1:0] core_q_valid;
  logic  [NUM_CORES-1:0] core_q_ready;
  addr_t [NUM_CORES-1:0] core_addr;
  logic  [NUM_CORES-1:0] core_write;
  data_t [NUM_CORES-1:0] core_wdata;
  strb_t [NUM_CORES-1:0] core_strb;
  logic  [NUM_CORES-1:0] core_p_valid;
  data_t [NUM_CORES-1:0] core_p_data;
  logic  [NUM_CORES-1:0] core_error;
  logic                  cache_q_valid;
  logic                  cache_q_ready;
  addr_t                 cache_addr;
  logic                  cache_write;
  data_t                 cache_wdata;
  strb_t                 cache_strb;
  core_id_t              cache_core_id;
  logic                  cache_p_valid;
  data_t                 cache_p_data;
  core_id_t              cache_p_core_id;
  logic                  cache_p_ready;
  int                    pending;
  int                    checks;
  int                    errors;

  line_t  lines[$];
  line_t  batch[$];
  line_t  late_cfg;
  logic   late_valid;
  int     cycles;
  int     limit;
  integer seed;
  data_t  cache_mem [addr_t];

  spm_subsys_top dut0 (
    .clk_i (clk), .arst_n_i (arst_n),
    .cfg_we_i (cfg_we), .cfg_addr_i (cfg_addr), .cfg_wdata_i (cfg_wdata),
    .core_q_valid_i (core_q_valid), .core_q_ready_o (core_q_ready),
    .core_addr_i (core_addr), .core_write_i (core_write),
    .core_wdata_i (core_wdata), .core_strb_i (core_strb),
    .core_p_valid_o (core_p_valid), .core_p_data_o (core_p_data),
    .core_error_o (core_error),
    .cache_q_valid_o (cache_q_valid), .cache_q_ready_i (cache_q_ready),
    .cache_addr_o (cache_addr), .cache_write_o (cache_write),
    .cache_wdata_o (cache_wdata), .cache_strb_o (cache_strb),
    .cache_core_id_o (cache_core_id), .cache_p_valid_i (cache_p_valid),
    .cache_p_data_i (cache_p_data), .cache_p_core_id_i (cache_p_core_id),
    .cache_p_ready_o (cache_p_ready)
  );

  spm_subsys_checker chk0 (
    .clk_i (clk), .arst_n_i (arst_n),
    .cfg_we_i (cfg_we), .cfg_addr_i (cfg_addr), .cfg_wdata_i (cfg_wdata),
    .core_q_valid_i (core_q_valid), .core_q_ready_i (core_q_ready),
    .core_addr_i (core_addr), .core_write_i (core_write),
    .core_wdata_i (core_wdata), .core_strb_i (core_strb),
    .core_p_valid_i (core_p_valid),
    .core_p_data_i (core_p_data), .core_error_i (core_error),
    .cache_q_valid_i (cache_q_valid), .cache_q_ready_i (cache_q_ready),
    .cache_addr_i (cache_addr), .cache_write_i (cache_write),
    .cache_wdata_i (cache_wdata), .cache_strb_i (cache_strb),
    .cache_core_id_i (cache_core_id),
    .cache_p_valid_i (cache_p_valid), .cache_p_data_i (cache_p_data),
    .cache_p_core_id_i (cache_p_core_id), .cache_p_ready_i (cache_p_ready),
    .pending_o (pending), .checks_o (checks), .errors_o (errors)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------------------
  task automatic load_lines();
    int    fd;
    int    n;
    string s;
    line_t l;
    fd = $fopen("sim/spm_subsys_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file");
      $display("CHECKS FAILED");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        s = "";
        void'($fgets(s, fd));
        if (s.len() < 2 || s[0] == "#") continue;
        n = $sscanf(s, "%d %d %d %h %h %h", l.op, l.core, l.kind, l.addr, l.data, l.exp);
        if (n == 6) lines.push_back(l);
      end
      $fclose(fd);
    end
  endtask

  task automatic cfg_write(input cfg_addr_t idx, input data_t val);
    @(posedge clk);
    #2;
    cfg_we    = 1'b1;
    cfg_addr  = idx;
    cfg_wdata = val;
    @(posedge clk);
    #2;
    cfg_we    = 1'b0;
  endtask

  // Issues the batch entries of one core back to back
  task automatic drive_core(input int c);
    logic ready;
    @(posedge clk);
    foreach (batch[k]) begin
      if (batch[k].core == c) begin
        #2;
        core_q_valid[c] = 1'b1;
        core_addr[c]    = batch[k].addr;
        core_write[c]   = (batch[k].op == 1);
        core_wdata[c]   = batch[k].data;
        chk0.add_expect(c, batch[k].kind, batch[k].op == 2, batch[k].exp);
        ready = 1'b0;
        while (!ready) begin
          @(negedge clk);
          ready = core_q_ready[c];
          @(posedge clk);
        end
      end
    end
    #2;
    core_q_valid[c] = 1'b0;
  endtask

  task automatic run_batch();
    fork
      drive_core(0);
      drive_core(1);
      begin
        if (late_valid) begin
          repeat (8) @(posedge clk);
          cfg_write(cfg_addr_t'(late_cfg.addr), late_cfg.data);
        end
      end
    join
    while (pending != 0) @(posedge clk);
    batch.delete();
    late_valid = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // Cache model, one request at a time, read data is address ^ FILL
  // until written
  // ----------------------------------------------------------------------
  initial begin
    addr_t    a;
    data_t    old;
    core_id_t id;
    int       lat;
    forever begin
      @(posedge clk);
      #2;
      cache_q_ready = 1'b1;
      @(negedge clk);
      if (arst_n && cache_q_valid) begin
        a   = cache_addr;
        id  = cache_core_id;
        old = cache_mem.exists(a) ? cache_mem[a] : (a ^ FILL);
        if (cache_write) cache_mem[a] = cache_wdata;
        @(posedge clk);
        #2;
        cache_q_ready = 1'b0;
        lat = 1 + ($unsigned($random(seed)) % 4);
        repeat (lat - 1) @(posedge clk);
        #2;
        cache_p_valid   = 1'b1;
        cache_p_data    = old;
        cache_p_core_id = id;
        @(negedge clk);
        while (!cache_p_ready) @(negedge clk);
        @(posedge clk);
        #2;
        cache_p_valid = 1'b0;
      end
    end
  end

  // Watchdog
  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (limit != 0 && cycles > limit) begin
        $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
        $display("CHECKS FAILED");
        $finish;
      end
    end
  end

  initial begin
    seed            = 32'h4d4e;
    limit           = 0;
    late_valid      = 1'b0;
    arst_n          = 1'b0;
    cfg_we          = 1'b0;
    cfg_addr        = '0;
    cfg_wdata       = '0;
    core_q_valid    = '0;
    core_addr       = '0;
    core_write      = '0;
    core_wdata      = '0;
    core_strb       = '1;
    cache_q_ready   = 1'b0;
    cache_p_valid   = 1'b0;
    cache_p_data    = '0;
    cache_p_core_id = '0;
    load_lines();
    limit = 20 * lines.size() + 200;
    repeat (10) @(posedge clk);
    #2;
    arst_n = 1'b1;
    foreach (lines[i]) begin
      case (lines[i].op)
        0: begin
          run_batch();
          cfg_write(cfg_addr_t'(lines[i].addr), lines[i].data);
        end
        1, 2: batch.push_back(lines[i]);
        3: run_batch();
        default: begin
          late_cfg   = lines[i];
          late_valid = 1'b1;
        end
      endcase
    end
    run_batch();
    repeat (5) @(posedge clk);
    $display("checks=%0d errors=%0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: sim/spm_subsys_input.txt
# op core kind addr data exp (hex); op 0 cfg (addr=index), 1 write, 2 read, 3 sync, 4 late cfg
# kind 0 SPM, 1 cache, 2 error; exp is the read data
1 0 0 10000400 11112222 0
1 1 0 100007fc 33334444 0
1 0 0 10000704 55556666 0
3 0 0 0 0 0
2 0 0 10000400 0 11112222
2 1 0 100007fc 0 33334444
2 0 1 20000000 0 7a5aa5a5
1 1 1 20000010 cafef00d 0
2 1 1 20000010 0 cafef00d
2 0 2 10000100 0 0
3 0 0 0 0 0
0 0 0 2 00000600 0
1 0 0 10000300 0badf00d 0
2 0 0 10000300 0 0badf00d
0 0 0 2 00000100 0
2 1 2 10000400 0 0
0 0 0 3 1 0
2 0 1 30000000 0 6a5aa5a5
2 1 0 100007fc 0 33334444
4 0 0 3 0 0
3 0 0 0 0 0
2 0 1 40000000 0 1a5aa5a5
2 0 0 10000704 0 55556666
2 1 1 40000004 0 1a5aa5a1
2 1 0 100007fc 0 33334444

// File: spm_subsys_top.f
hdl/spm_map_pkg.sv
hdl/mem_port_if.sv
hdl/spm_cfg_regs.sv
hdl/spm_addr_mapper.sv
hdl/cache_port_arb.sv
hdl/spm_bank.sv
hdl/spm_subsys_top.sv
sim/spm_subsys_checker.sv
sim/spm_subsys_tb.sv

// File: Bender.yml
package:
  name: spm_subsys

sources:
  - hdl/spm_map_pkg.sv
  - hdl/mem_port_if.sv
  - hdl/spm_cfg_regs.sv
  - hdl/spm_addr_mapper.sv
  - hdl/cache_port_arb.sv
  - hdl/spm_bank.sv
  - hdl/spm_subsys_top.sv
  - target: simulation
    files:
      - sim/spm_subsys_checker.sv
      - sim/spm_subsys_tb.sv
